//--- all.f
+incdir+tests
common/mcore_mem_pkg.sv
rtl/mcore_mem_xbar.sv
mem/mcore_sec_mem.sv
rtl/mcore_proc_resp_acc.sv
rtl/mcore_mem_top.sv
tests/mcore_mem_tb.sv

//--- common/mcore_mem_pkg.sv
// shared definitions for the multicore tagged memory
// word width, security levels, request types and the payload union

package mcore_mem_pkg;

	//========================================
	// word width and security levels
	//========================================

	// data word width, the payload union below depends on it
	localparam int word_nbits = 32;

	// one-bit security level, 0 is low and 1 is high
	typedef logic sec_level_t;

	localparam sec_level_t sec_low  = 1'b0;
	localparam sec_level_t sec_high = 1'b1;

	//========================================
	// request types
	//========================================

	// read returns the word and its tag
	// write stores data subject to the tag rule
	// set_level changes the tag, high requesters only
	typedef enum logic [1:0] {
		req_read      = 2'd0,
		req_write     = 2'd1,
		req_set_level = 2'd2
	} mem_req_type_e;

	//========================================
	// payload word
	//========================================

	// level-control view of a payload word
	// only the lsb carries meaning, the rest is reserved
	typedef struct packed {
		logic [word_nbits-2:0] reserved;
		sec_level_t            new_level;
	} mem_level_ctl_t;

	// one payload word, read as plain data for reads and writes
	// and as a level-control word for set_level requests
	typedef union packed {
		logic [word_nbits-1:0] data;
		mem_level_ctl_t        level;
	} mem_word_u;

endpackage

//--- mem/mcore_sec_mem.sv
// tagged memory with one registered response stage
// applies the write and set-level rules of the security tags

`timescale 1ns/10ps

module mcore_sec_mem #(
	parameter int num_ports  = 2,
	parameter int addr_nbits = 6
) (
	input  logic clk,
	input  logic rst,

	// request side
	input  logic                                                   mem_req_val,
	input  mcore_mem_pkg::mem_req_type_e                           mem_req_type,
	input  logic [addr_nbits-1:0]                                  mem_req_addr,
	input  mcore_mem_pkg::mem_word_u                               mem_req_data,
	input  logic [((num_ports > 1) ? $clog2(num_ports) : 1)-1:0]   mem_req_port,
	input  mcore_mem_pkg::sec_level_t                              mem_req_level,
	output logic                                                   mem_req_rdy,

	// response side, straight from the output register
	output logic                                                   mem_resp_val,
	output mcore_mem_pkg::mem_req_type_e                           mem_resp_type,
	output mcore_mem_pkg::mem_word_u                               mem_resp_data,
	output logic [((num_ports > 1) ? $clog2(num_ports) : 1)-1:0]   mem_resp_port,
	output mcore_mem_pkg::sec_level_t                              mem_resp_level,
	input  logic                                                   mem_resp_rdy
);

	localparam int port_nbits = (num_ports > 1) ? $clog2(num_ports) : 1;
	localparam int mem_depth  = 1 << addr_nbits;

	// data words and their security tags
	logic [mcore_mem_pkg::word_nbits-1:0] data_mem [mem_depth];
	mcore_mem_pkg::sec_level_t            tag_mem  [mem_depth];

	logic                      req_xfer;
	mcore_mem_pkg::sec_level_t cur_tag;
	logic                      req_high;
	logic                      do_write;
	logic                      do_set;
	mcore_mem_pkg::sec_level_t next_tag;
	mcore_mem_pkg::mem_word_u  next_data;

	//========================================
	// request decode
	//========================================

	// accept when the output register is empty or draining now
	assign mem_req_rdy = !mem_resp_val || mem_resp_rdy;
	assign req_xfer    = mem_req_val && mem_req_rdy;

	assign cur_tag  = tag_mem[mem_req_addr];
	assign req_high = (mem_req_level == mcore_mem_pkg::sec_high);

	// low requester may not overwrite a high word
	assign do_write = req_xfer && (mem_req_type == mcore_mem_pkg::req_write)
		&& (req_high || cur_tag == mcore_mem_pkg::sec_low);

	// tag change needs a high requester
	assign do_set = req_xfer && (mem_req_type == mcore_mem_pkg::req_set_level) && req_high;

	// tag after the operation, new level taken through the level view
	assign next_tag = do_set ? mem_req_data.level.new_level : cur_tag;

	// only reads return data, writes and set_level return zero
	always_comb begin
		next_data = '0;
		if (mem_req_type == mcore_mem_pkg::req_read) begin
			next_data.data = data_mem[mem_req_addr];
		end
	end

	//========================================
	// storage
	//========================================

	// reset loop clears every word and drops every tag to low
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < mem_depth; i++) begin
				data_mem[i] <= '0;
				tag_mem[i]  <= mcore_mem_pkg::sec_low;
			end
		end else begin
			if (do_write) begin
				data_mem[mem_req_addr] <= mem_req_data.data;
			end
			if (do_set) begin
				tag_mem[mem_req_addr] <= next_tag;
			end
		end
	end

	//========================================
	// response register
	//========================================

	// valid bit, loads on accept and clears once drained
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_resp_val <= 1'b0;
		end else if (req_xfer) begin
			mem_resp_val <= 1'b1;
		end else if (mem_resp_rdy) begin
			mem_resp_val <= 1'b0;
		end
	end

	// payload only changes on accept
	always_ff @(posedge clk) begin
		if (req_xfer) begin
			mem_resp_type  <= mem_req_type;
			mem_resp_data  <= next_data;
			mem_resp_port  <= port_nbits'(mem_req_port);
			mem_resp_level <= next_tag;
		end
	end

endmodule

//--- rtl/mcore_mem_top.sv
// multicore memory subsystem top level
// crossbar, tagged memory and one response access-control block per port

`timescale 1ns/10ps

module mcore_mem_top #(
	parameter int num_ports  = 2,
	parameter int addr_nbits = 6
) (
	input  logic clk,
	input  logic rst,
	input  mcore_mem_pkg::sec_level_t    [num_ports-1:0]                 proc_sec_level,

	// request group
	input  logic                         [num_ports-1:0]                 proc_req_val,
	input  mcore_mem_pkg::mem_req_type_e [num_ports-1:0]                 proc_req_type,
	input  logic                         [num_ports-1:0][addr_nbits-1:0] proc_req_addr,
	input  mcore_mem_pkg::mem_word_u     [num_ports-1:0]                 proc_req_data,
	output logic                         [num_ports-1:0]                 proc_req_rdy,

	// response group
	output logic                         [num_ports-1:0]                 proc_resp_val,
	output mcore_mem_pkg::mem_req_type_e [num_ports-1:0]                 proc_resp_type,
	output mcore_mem_pkg::mem_word_u     [num_ports-1:0]                 proc_resp_data,
	input  logic                         [num_ports-1:0]                 proc_resp_rdy
);

	localparam int port_nbits = (num_ports > 1) ? $clog2(num_ports) : 1;

	// crossbar to memory
	logic                         mem_req_val;
	mcore_mem_pkg::mem_req_type_e mem_req_type;
	logic [addr_nbits-1:0]        mem_req_addr;
	mcore_mem_pkg::mem_word_u     mem_req_data;
	logic [port_nbits-1:0]        mem_req_port;
	mcore_mem_pkg::sec_level_t    mem_req_level;
	logic                         mem_req_rdy;

	// memory to crossbar
	logic                         mem_resp_val;
	mcore_mem_pkg::mem_req_type_e mem_resp_type;
	mcore_mem_pkg::mem_word_u     mem_resp_data;
	logic [port_nbits-1:0]        mem_resp_port;
	mcore_mem_pkg::sec_level_t    mem_resp_level;
	logic                         mem_resp_rdy;

	// crossbar to access control, per port
	logic                         [num_ports-1:0] net_resp_val;
	mcore_mem_pkg::mem_req_type_e [num_ports-1:0] net_resp_type;
	mcore_mem_pkg::mem_word_u     [num_ports-1:0] net_resp_data;
	mcore_mem_pkg::sec_level_t    [num_ports-1:0] net_resp_level;
	logic                         [num_ports-1:0] net_resp_rdy;

	//========================================
	// crossbar and memory
	//========================================

	mcore_mem_xbar #(
		.num_ports  (num_ports),
		.addr_nbits (addr_nbits)
	) xbar0 (
		.clk            (clk),
		.rst            (rst),
		.proc_sec_level (proc_sec_level),
		.proc_req_val   (proc_req_val),
		.proc_req_type  (proc_req_type),
		.proc_req_addr  (proc_req_addr),
		.proc_req_data  (proc_req_data),
		.proc_req_rdy   (proc_req_rdy),
		.mem_req_val    (mem_req_val),
		.mem_req_type   (mem_req_type),
		.mem_req_addr   (mem_req_addr),
		.mem_req_data   (mem_req_data),
		.mem_req_port   (mem_req_port),
		.mem_req_level  (mem_req_level),
		.mem_req_rdy    (mem_req_rdy),
		.mem_resp_val   (mem_resp_val),
		.mem_resp_type  (mem_resp_type),
		.mem_resp_data  (mem_resp_data),
		.mem_resp_port  (mem_resp_port),
		.mem_resp_level (mem_resp_level),
		.mem_resp_rdy   (mem_resp_rdy),
		.net_resp_val   (net_resp_val),
		.net_resp_type  (net_resp_type),
		.net_resp_data  (net_resp_data),
		.net_resp_level (net_resp_level),
		.net_resp_rdy   (net_resp_rdy)
	);

	mcore_sec_mem #(
		.num_ports  (num_ports),
		.addr_nbits (addr_nbits)
	) mem0 (
		.clk            (clk),
		.rst            (rst),
		.mem_req_val    (mem_req_val),
		.mem_req_type   (mem_req_type),
		.mem_req_addr   (mem_req_addr),
		.mem_req_data   (mem_req_data),
		.mem_req_port   (mem_req_port),
		.mem_req_level  (mem_req_level),
		.mem_req_rdy    (mem_req_rdy),
		.mem_resp_val   (mem_resp_val),
		.mem_resp_type  (mem_resp_type),
		.mem_resp_data  (mem_resp_data),
		.mem_resp_port  (mem_resp_port),
		.mem_resp_level (mem_resp_level),
		.mem_resp_rdy   (mem_resp_rdy)
	);

	//========================================
	// per-port access control
	//========================================

	for (genvar p = 0; p < num_ports; p++) begin : g_acc
		mcore_proc_resp_acc acc (
			.net_resp_val   (net_resp_val[p]),
			.net_resp_type  (net_resp_type[p]),
			.net_resp_data  (net_resp_data[p]),
			.net_resp_level (net_resp_level[p]),
			.net_resp_rdy   (net_resp_rdy[p]),
			.proc_sec_level (proc_sec_level[p]),
			.proc_resp_val  (proc_resp_val[p]),
			.proc_resp_type (proc_resp_type[p]),
			.proc_resp_data (proc_resp_data[p]),
			.proc_resp_rdy  (proc_resp_rdy[p])
		);
	end

endmodule

//--- rtl/mcore_mem_xbar.sv
// round-robin request crossbar for the shared memory
// response demux back to the requesting port by port id

`timescale 1ns/10ps

module mcore_mem_xbar #(
	parameter int num_ports  = 2,
	parameter int addr_nbits = 6
) (
	input  logic clk,
	input  logic rst,
	input  mcore_mem_pkg::sec_level_t    [num_ports-1:0]                 proc_sec_level,

	// requests from the processor ports
	input  logic                         [num_ports-1:0]                 proc_req_val,
	input  mcore_mem_pkg::mem_req_type_e [num_ports-1:0]                 proc_req_type,
	input  logic                         [num_ports-1:0][addr_nbits-1:0] proc_req_addr,
	input  mcore_mem_pkg::mem_word_u     [num_ports-1:0]                 proc_req_data,
	output logic                         [num_ports-1:0]                 proc_req_rdy,

	// single request stream into the memory
	output logic                                                   mem_req_val,
	output mcore_mem_pkg::mem_req_type_e                           mem_req_type,
	output logic [addr_nbits-1:0]                                  mem_req_addr,
	output mcore_mem_pkg::mem_word_u                               mem_req_data,
	output logic [((num_ports > 1) ? $clog2(num_ports) : 1)-1:0]   mem_req_port,
	output mcore_mem_pkg::sec_level_t                              mem_req_level,
	input  logic                                                   mem_req_rdy,

	// single response stream out of the memory
	input  logic                                                   mem_resp_val,
	input  mcore_mem_pkg::mem_req_type_e                           mem_resp_type,
	input  mcore_mem_pkg::mem_word_u                               mem_resp_data,
	input  logic [((num_ports > 1) ? $clog2(num_ports) : 1)-1:0]   mem_resp_port,
	input  mcore_mem_pkg::sec_level_t                              mem_resp_level,
	output logic                                                   mem_resp_rdy,

	// responses toward the access-control blocks
	output logic                         [num_ports-1:0]           net_resp_val,
	output mcore_mem_pkg::mem_req_type_e [num_ports-1:0]           net_resp_type,
	output mcore_mem_pkg::mem_word_u     [num_ports-1:0]           net_resp_data,
	output mcore_mem_pkg::sec_level_t    [num_ports-1:0]           net_resp_level,
	input  logic                         [num_ports-1:0]           net_resp_rdy
);

	localparam int port_nbits = (num_ports > 1) ? $clog2(num_ports) : 1;

	logic [port_nbits-1:0] rr_ptr;
	logic [port_nbits-1:0] pick_idx;
	logic                  pick_found;
	logic                  lock_val;
	logic [port_nbits-1:0] lock_idx;
	logic [port_nbits-1:0] grant_idx;
	logic                  req_xfer;

	//========================================
	// request arbitration
	//========================================

	// first valid port at or after the pointer
	always_comb begin : rr_pick
		int idx;
		pick_found = 1'b0;
		pick_idx   = '0;
		for (int i = 0; i < num_ports; i++) begin
			idx = (int'(rr_ptr) + i) % num_ports;
			if (!pick_found && proc_req_val[idx]) begin
				pick_found = 1'b1;
				pick_idx   = port_nbits'(idx);
			end
		end
	end

	// a stalled grant stays locked so the memory side payload holds steady
	assign grant_idx   = lock_val ? lock_idx : pick_idx;
	assign mem_req_val = lock_val | pick_found;
	assign req_xfer    = mem_req_val & mem_req_rdy;

	// only the granted port sees ready
	always_comb begin
		for (int p = 0; p < num_ports; p++) begin
			proc_req_rdy[p] = req_xfer && (grant_idx == port_nbits'(p));
		end
	end

	// pointer moves one past the granted port on each accepted request
	always_ff @(posedge clk) begin
		if (rst) begin
			rr_ptr   <= '0;
			lock_val <= 1'b0;
			lock_idx <= '0;
		end else if (req_xfer) begin
			rr_ptr   <= (int'(grant_idx) == num_ports - 1) ? '0 : grant_idx + 1'b1;
			lock_val <= 1'b0;
		end else if (mem_req_val) begin
			lock_val <= 1'b1;
			lock_idx <= grant_idx;
		end
	end

	// payload mux, tagged with port id and that port's level
	assign mem_req_type  = proc_req_type[grant_idx];
	assign mem_req_addr  = proc_req_addr[grant_idx];
	assign mem_req_data  = proc_req_data[grant_idx];
	assign mem_req_port  = grant_idx;
	assign mem_req_level = proc_sec_level[grant_idx];

	//========================================
	// response demux
	//========================================

	// payload goes to every port, valid only to the owner
	for (genvar p = 0; p < num_ports; p++) begin : g_resp
		assign net_resp_val[p]   = mem_resp_val && (mem_resp_port == port_nbits'(p));
		assign net_resp_type[p]  = mem_resp_type;
		assign net_resp_data[p]  = mem_resp_data;
		assign net_resp_level[p] = mem_resp_level;
	end

	assign mem_resp_rdy = net_resp_rdy[mem_resp_port];

endmodule

//--- rtl/mcore_proc_resp_acc.sv
// response access control in front of one processor port
// masks data of a response above the processor level

`timescale 1ns/10ps

module mcore_proc_resp_acc (
	// from the crossbar
	input  logic                         net_resp_val,
	input  mcore_mem_pkg::mem_req_type_e net_resp_type,
	input  mcore_mem_pkg::mem_word_u     net_resp_data,
	input  mcore_mem_pkg::sec_level_t    net_resp_level,
	output logic                         net_resp_rdy,

	// level of the processor behind this port
	input  mcore_mem_pkg::sec_level_t    proc_sec_level,

	// to the processor
	output logic                         proc_resp_val,
	output mcore_mem_pkg::mem_req_type_e proc_resp_type,
	output mcore_mem_pkg::mem_word_u     proc_resp_data,
	input  logic                         proc_resp_rdy
);

	//========================================
	// level check
	//========================================

	always_comb begin
		// handshake and type always pass so the requester never hangs
		proc_resp_val  = net_resp_val;
		net_resp_rdy   = proc_resp_rdy;
		proc_resp_type = net_resp_type;

		// response level at or below the processor level
		if (net_resp_level <= proc_sec_level) begin
			proc_resp_data = net_resp_data;
		end
		// high response to a low processor, secret dropped
		else begin
			proc_resp_data = '0;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# build the simulation with Verilator, run it, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module mcore_mem_tb -o mcore_mem_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/mcore_mem_sim 2>&1 | tee sim.log
grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- tests/mcore_mem_checks.svh
// reference model of the tagged memory and per-port expected-response queues
// typed compare tasks for the response type and the response data

`ifndef mcore_mem_checks_svh
`define mcore_mem_checks_svh

//========================================
// reference model
//========================================

// model starts like the DUT after reset with zero data and low tags everywhere
logic [mcore_mem_pkg::word_nbits-1:0] model_data [1 << addr_nbits] = '{default: '0};
mcore_mem_pkg::sec_level_t            model_tag  [1 << addr_nbits] = '{default: 1'b0};

// expected responses per port in issue order
mcore_mem_pkg::mem_req_type_e exp_type_q [num_ports][$];
mcore_mem_pkg::mem_word_u     exp_data_q [num_ports][$];

// apply one accepted request, then queue what its port should get back
task automatic apply_request(input int port, input mcore_mem_pkg::mem_req_type_e rtype,
		input logic [addr_nbits-1:0] addr, input mcore_mem_pkg::mem_word_u wdata);
	mcore_mem_pkg::sec_level_t lvl;
	mcore_mem_pkg::mem_word_u  exp;
	logic                      denied;
	lvl    = proc_sec_level[port];
	exp    = '0;
	// high word and low processor
	denied = (model_tag[addr] == mcore_mem_pkg::sec_high) && (lvl == mcore_mem_pkg::sec_low);
	case (rtype)
		// a high word seen by a low processor reads as zero
		mcore_mem_pkg::req_read: begin
			if (!denied)
				exp.data = model_data[addr];
		end
		// low writer cannot touch a high word
		mcore_mem_pkg::req_write: begin
			if (!denied)
				model_data[addr] = wdata.data;
		end
		// tag moves only for a high requester
		default: begin
			if (lvl == mcore_mem_pkg::sec_high)
				model_tag[addr] = wdata.level.new_level;
		end
	endcase
	exp_type_q[port].push_back(rtype);
	exp_data_q[port].push_back(exp);
endtask

//========================================
// compare tasks
//========================================

task automatic check_type(input int port, input mcore_mem_pkg::mem_req_type_e got,
		input mcore_mem_pkg::mem_req_type_e exp);
	if (got !== exp)
		fail_stop($sformatf("CHECK FAILED time %0t proc_resp_type[%0d] got %s expected %s",
			$time, port, got.name(), exp.name()));
endtask

task automatic check_data(input int port, input mcore_mem_pkg::mem_word_u got,
		input mcore_mem_pkg::mem_word_u exp);
	if (got !== exp)
		fail_stop($sformatf("CHECK FAILED time %0t proc_resp_data[%0d] got %h expected %h",
			$time, port, got.data, exp.data));
endtask

// one response handshake against the head of that port's queue
task automatic check_response(input int port);
	if (exp_type_q[port].size() == 0)
		fail_stop($sformatf("port %0d got a response with no request outstanding", port));
	check_type(port, proc_resp_type[port], exp_type_q[port].pop_front());
	check_data(port, proc_resp_data[port], exp_data_q[port].pop_front());
	resp_count++;
endtask

`endif

//--- tests/mcore_mem_tb.sv
// testbench for the multicore tagged memory
// directed security phases, then random traffic with response back-pressure

`timescale 1ns/10ps

module mcore_mem_tb;

	localparam int num_ports  = 2;
	localparam int addr_nbits = 6;
	// directed phases issue 64 requests, the random phase adds n_rand per port
	localparam int n_rand     = 150;
	localparam int n_total    = 64 + num_ports * n_rand;

	typedef struct packed {
		mcore_mem_pkg::mem_req_type_e rtype;
		logic [addr_nbits-1:0]        addr;
		mcore_mem_pkg::mem_word_u     data;
	} stim_req_t;

	logic clk = 1'b0;
	logic rst = 1'b1;
	// port 0 is high, port 1 is low
	mcore_mem_pkg::sec_level_t    [num_ports-1:0]                 proc_sec_level = 2'b01;
	logic                         [num_ports-1:0]                 proc_req_val   = '0;
	mcore_mem_pkg::mem_req_type_e [num_ports-1:0]                 proc_req_type  = '0;
	logic                         [num_ports-1:0][addr_nbits-1:0] proc_req_addr  = '0;
	mcore_mem_pkg::mem_word_u     [num_ports-1:0]                 proc_req_data  = '0;
	logic                         [num_ports-1:0]                 proc_req_rdy;
	logic                         [num_ports-1:0]                 proc_resp_val;
	mcore_mem_pkg::mem_req_type_e [num_ports-1:0]                 proc_resp_type;
	mcore_mem_pkg::mem_word_u     [num_ports-1:0]                 proc_resp_data;
	logic                         [num_ports-1:0]                 proc_resp_rdy  = '0;

	integer    seed         = 32'h365e_d78e;
	stim_req_t stim_q [num_ports][$];
	logic      gap_en       = 1'b0;
	logic      any_accepted = 1'b0;
	int        resp_count   = 0;

	task automatic fail_stop(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	`include "mcore_mem_checks.svh"

	mcore_mem_top #(
		.num_ports  (num_ports),
		.addr_nbits (addr_nbits)
	) dut0 (
		.clk            (clk),
		.rst            (rst),
		.proc_sec_level (proc_sec_level),
		.proc_req_val   (proc_req_val),
		.proc_req_type  (proc_req_type),
		.proc_req_addr  (proc_req_addr),
		.proc_req_data  (proc_req_data),
		.proc_req_rdy   (proc_req_rdy),
		.proc_resp_val  (proc_resp_val),
		.proc_resp_type (proc_resp_type),
		.proc_resp_data (proc_resp_data),
		.proc_resp_rdy  (proc_resp_rdy)
	);

	always #10 clk = ~clk;

	//========================================
	// drivers and monitor
	//========================================

	// next request goes out once the current one is taken, with optional idle gaps
	always @(posedge clk) begin : drive_requests
		stim_req_t nxt;
		if (!rst) begin
			for (int p = 0; p < num_ports; p++) begin
				if (!proc_req_val[p] || proc_req_rdy[p]) begin
					if (stim_q[p].size() > 0 && !(gap_en && ({$random(seed)} % 4) == 0)) begin
						nxt = stim_q[p].pop_front();
						proc_req_val[p]  <= 1'b1;
						proc_req_type[p] <= nxt.rtype;
						proc_req_addr[p] <= nxt.addr;
						proc_req_data[p] <= nxt.data;
					end else begin
						proc_req_val[p] <= 1'b0;
					end
				end
			end
		end
	end

	// ready is low about one cycle in four
	always @(posedge clk) begin
		for (int p = 0; p < num_ports; p++)
			proc_resp_rdy[p] <= ({$random(seed)} % 4) != 0;
	end

	// responses are checked before this edge's requests reach the model
	always @(posedge clk) begin : monitor
		if (!rst) begin
			if (!any_accepted && proc_resp_val != '0)
				fail_stop("a response became valid before any request was accepted");
			if ($countones(proc_req_val & proc_req_rdy) > 1)
				fail_stop("more than one request was accepted in a single cycle");
			for (int p = 0; p < num_ports; p++)
				if (proc_resp_val[p] && proc_resp_rdy[p])
					check_response(p);
			for (int p = 0; p < num_ports; p++) begin
				if (proc_req_val[p] && proc_req_rdy[p]) begin
					apply_request(p, proc_req_type[p], proc_req_addr[p], proc_req_data[p]);
					any_accepted = 1'b1;
				end
			end
		end
	end

	task automatic push_req(input int port, input mcore_mem_pkg::mem_req_type_e rtype,
			input int addr, input mcore_mem_pkg::mem_word_u data);
		stim_req_t s;
		s.rtype = rtype;
		s.addr  = addr_nbits'(addr);
		s.data  = data;
		stim_q[port].push_back(s);
	endtask

	// nothing queued, nothing on the request ports, nothing outstanding
	task automatic wait_idle();
		logic busy;
		busy = 1'b1;
		while (busy) begin
			@(negedge clk);
			busy = (proc_req_val != '0);
			for (int p = 0; p < num_ports; p++)
				busy = busy || stim_q[p].size() > 0 || exp_type_q[p].size() > 0;
		end
	endtask

	//========================================
	// test sequence
	//========================================

	initial begin : stimulus
		mcore_mem_pkg::mem_word_u d;
		logic [31:0]              r;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		// each port fills its own words, then reads them back
		for (int i = 0; i < 8; i++) begin
			d.data = $random(seed);
			push_req(0, mcore_mem_pkg::req_write, i, d);
			d.data = $random(seed);
			push_req(1, mcore_mem_pkg::req_write, 8 + i, d);
		end
		for (int i = 0; i < 8; i++) begin
			push_req(0, mcore_mem_pkg::req_read, i, '0);
			push_req(1, mcore_mem_pkg::req_read, 8 + i, '0);
		end
		wait_idle();
		// high port marks words 0 to 3 high with random reserved bits
		for (int i = 0; i < 4; i++) begin
			d.data            = $random(seed);
			d.level.new_level = mcore_mem_pkg::sec_high;
			push_req(0, mcore_mem_pkg::req_set_level, i, d);
		end
		wait_idle();
		for (int i = 0; i < 4; i++) begin
			push_req(1, mcore_mem_pkg::req_read, i, '0);
			push_req(0, mcore_mem_pkg::req_read, i, '0);
		end
		wait_idle();
		// low port tries to raise its own words and to lower two high ones
		for (int i = 0; i < 6; i++) begin
			d.data            = $random(seed);
			d.level.new_level = (i < 4) ? mcore_mem_pkg::sec_high : mcore_mem_pkg::sec_low;
			push_req(1, mcore_mem_pkg::req_set_level, (i < 4) ? 8 + i : i - 4, d);
		end
		wait_idle();
		for (int i = 0; i < 6; i++)
			push_req(1, mcore_mem_pkg::req_read, (i < 4) ? 8 + i : i - 4, '0);
		wait_idle();
		// low port overwrites high words, high port checks they kept their value
		for (int i = 0; i < 4; i++) begin
			d.data = $random(seed);
			push_req(1, mcore_mem_pkg::req_write, i, d);
		end
		wait_idle();
		for (int i = 0; i < 4; i++)
			push_req(0, mcore_mem_pkg::req_read, i, '0);
		wait_idle();
		// random mix from both ports at once
		gap_en = 1'b1;
		for (int i = 0; i < n_rand; i++) begin
			for (int p = 0; p < num_ports; p++) begin
				r                 = $random(seed);
				d.data            = $random(seed);
				d.level.new_level = r[8];
				case (r[31:16] % 3)
					0:       push_req(p, mcore_mem_pkg::req_read, int'(r[addr_nbits-1:0]), d);
					1:       push_req(p, mcore_mem_pkg::req_write, int'(r[addr_nbits-1:0]), d);
					default: push_req(p, mcore_mem_pkg::req_set_level, int'(r[addr_nbits-1:0]), d);
				endcase
			end
		end
		wait_idle();
		// every request answered, so no port may still hold a response
		if (proc_resp_val != '0)
			fail_stop("a response is still valid after every request was answered");
		else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

	// about 20 cycles per request is far beyond any legal latency
	initial begin : watchdog
		#(n_total * 20 * 20);
		fail_stop($sformatf("watchdog expired with %0d of %0d responses seen",
			resp_count, n_total));
	end

endmodule
